/* apb_adv_timer.f */
+incdir+include
verilog/adv_timer_reg_pkg.sv
verilog/adv_timer_pkg.sv
verilog/apb_adv_timer_regs.sv
verilog/adv_timer_ctrl_fsm.sv
verilog/adv_timer_counter.sv
verilog/adv_timer_comp_ch.sv
verilog/adv_timer_event_unit.sv
verilog/apb_adv_timer.sv
tests/tb_apb_adv_timer.sv

/* tests/tb_apb_adv_timer.sv */
// Directed testbench of the APB PWM timer
// APB access tasks, value check, register, counter, channel and event tests

`timescale 1ns/100ps
`include "adv_timer_cfg.svh"

module tb_apb_adv_timer;

	localparam int CLK_HALF   = 20;
	localparam int DRIVE_DLY  = 2;
	localparam int SAMPLE_DLY = CLK_HALF - DRIVE_DLY;

	localparam logic [31:0] CMD_START  = 32'h1 << adv_timer_reg_pkg::CMD_START_BIT;
	localparam logic [31:0] CMD_STOP   = 32'h1 << adv_timer_reg_pkg::CMD_STOP_BIT;
	localparam logic [31:0] CMD_UPDATE = 32'h1 << adv_timer_reg_pkg::CMD_UPDATE_BIT;
	localparam logic [31:0] CMD_RST    = 32'h1 << adv_timer_reg_pkg::CMD_RST_BIT;

	logic                         HCLK;
	logic                         HRESETn;
	logic [`ADV_TIMER_ADDR_W-1:0] PADDR_i;
	logic [31:0]                  PWDATA_i;
	logic                         PWRITE_i;
	logic                         PSEL_i;
	logic                         PENABLE_i;
	logic [31:0]                  PRDATA_o;
	logic                         PREADY_o;
	logic                         PSLVERR_o;
	logic [`ADV_TIMER_N_CH-1:0]   ch_o;
	logic [`ADV_TIMER_N_CH-1:0]   events_o;

	int          check_count;
	int          error_count;
	int          timeout_count;
	logic [31:0] rng;

	apb_adv_timer DUT (.*);

	initial begin
		HCLK = 1'b0;
		forever #(CLK_HALF) HCLK = ~HCLK;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [11:0] addr_of(input adv_timer_reg_pkg::reg_addr_e r);
		return 12'(r);
	endfunction

	// Field packing by the register map
	function automatic logic [31:0] cfg_word(input logic saw, input logic [7:0] presc);
		return (32'(saw) << adv_timer_reg_pkg::CFG_SAW_BIT) |
		       (32'(presc) << adv_timer_reg_pkg::CFG_PRESC_LSB);
	endfunction

	function automatic logic [31:0] th_word(input logic [15:0] low, input logic [15:0] hi);
		return (32'(hi) << adv_timer_reg_pkg::TH_HI_LSB) | 32'(low);
	endfunction

	function automatic logic [31:0] ch_word(input logic [2:0] op, input logic [15:0] th);
		return (32'(op) << adv_timer_reg_pkg::CH_OP_LSB) | 32'(th);
	endfunction

	task automatic check(input string test, input logic [31:0] expected,
	                     input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("ERROR %s: expected %h, actual %h", test, expected, actual);
		end
	endtask

	task automatic note_timeout(input string what);
		timeout_count++;
		$display("Timeout: %s", what);
	endtask

	//////////////////////////////////////////////////////////////////////
	// APB accesses, setup cycle then access cycle

	task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
	                          output logic [31:0] rdata, output logic err);
		int waited;
		@(posedge HCLK);
		#(DRIVE_DLY);
		PSEL_i    = 1'b1;
		PENABLE_i = 1'b0;
		PWRITE_i  = wr;
		PADDR_i   = addr;
		PWDATA_i  = wdata;
		@(posedge HCLK);
		#(DRIVE_DLY);
		PENABLE_i = 1'b1;
		#(SAMPLE_DLY);
		waited = 0;
		while (!PREADY_o && waited < 16) begin
			@(posedge HCLK);
			#(CLK_HALF);
			waited++;
		end
		if (!PREADY_o)
			note_timeout("PREADY stayed low during an APB access");
		rdata = PRDATA_o;
		err   = PSLVERR_o;
		@(posedge HCLK);
		#(DRIVE_DLY);
		PSEL_i    = 1'b0;
		PENABLE_i = 1'b0;
		PWRITE_i  = 1'b0;
	endtask

	task automatic apb_write(input string test, input logic [11:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		logic        err;
		apb_access(1'b1, addr, data, unused, err);
		check({test, " write response"}, 32'd0, 32'(err));
	endtask

	task automatic apb_read(input string test, input logic [11:0] addr, output logic [31:0] data);
		logic err;
		apb_access(1'b0, addr, 32'd0, data, err);
		check({test, " read response"}, 32'd0, 32'(err));
	endtask

	task automatic read_count(input string test, output logic [15:0] cnt);
		logic [31:0] data;
		apb_read(test, addr_of(adv_timer_reg_pkg::REG_CNT), data);
		cnt = data[15:0];
	endtask

	task automatic cmd(input string test, input logic [31:0] word);
		apb_write(test, addr_of(adv_timer_reg_pkg::REG_CMD), word);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests

	task automatic reg_readback();
		adv_timer_reg_pkg::reg_addr_e regs [7];
		logic [31:0]                  masks [7];
		logic [31:0]                  rd;
		logic                         err;
		regs  = '{adv_timer_reg_pkg::REG_CFG, adv_timer_reg_pkg::REG_TH,
		          adv_timer_reg_pkg::REG_CH0, adv_timer_reg_pkg::REG_CH1,
		          adv_timer_reg_pkg::REG_CH2, adv_timer_reg_pkg::REG_CH3,
		          adv_timer_reg_pkg::REG_EVT};
		// CFG saw and presc, full TH, CH threshold and op, EVT select and enable
		masks = '{32'h00FF_1000, 32'hFFFF_FFFF, 32'h0007_FFFF, 32'h0007_FFFF,
		          32'h0007_FFFF, 32'h0007_FFFF, 32'h0000_0FFF};
		for (int i = 0; i < 7; i++) begin
			rng = xorshift(rng);
			apb_write("reg_readback", addr_of(regs[i]), rng);
			apb_read("reg_readback", addr_of(regs[i]), rd);
			check("reg_readback", rng & masks[i], rd);
		end
		apb_read("reg_readback", addr_of(adv_timer_reg_pkg::REG_CMD), rd);
		check("reg_readback CMD", 32'd0, rd);
		apb_access(1'b0, 12'h040, 32'd0, rd, err);
		check("reg_readback unmapped read", 32'd1, 32'(err));
		apb_access(1'b1, 12'h040, 32'hFFFF_FFFF, rd, err);
		check("reg_readback unmapped write", 32'd1, 32'(err));
		apb_write("reg_readback", addr_of(adv_timer_reg_pkg::REG_EVT), 32'd0);
	endtask

	task automatic reset_and_stop();
		logic [15:0] c0;
		logic [15:0] c1;
		int          reads;
		apb_write("reset_and_stop", addr_of(adv_timer_reg_pkg::REG_TH), th_word(16'd10, 16'd200));
		apb_write("reset_and_stop", addr_of(adv_timer_reg_pkg::REG_CFG), cfg_word(1'b1, 8'd0));
		cmd("reset_and_stop", CMD_UPDATE);
		cmd("reset_and_stop", CMD_START);
		reads = 0;
		c0 = 16'd0;
		while (c0 < 16'd20 && reads < 100) begin
			read_count("reset_and_stop", c0);
			reads++;
		end
		if (c0 < 16'd20)
			note_timeout("counter did not advance after start");
		cmd("reset_and_stop", CMD_STOP);
		read_count("reset_and_stop", c0);
		repeat (10) @(posedge HCLK);
		read_count("reset_and_stop", c1);
		check("reset_and_stop held after stop", 32'(c0), 32'(c1));
		// Held count is above low, so the reset command must bring it back
		cmd("reset_and_stop", CMD_RST);
		read_count("reset_and_stop", c0);
		check("reset_and_stop after reset", 32'd10, 32'(c0));
	endtask

	task automatic sawtooth_range();
		logic [15:0] prev;
		logic [15:0] cur;
		int          outside;
		int          wraps;
		apb_write("sawtooth_range", addr_of(adv_timer_reg_pkg::REG_TH), th_word(16'd5, 16'd20));
		apb_write("sawtooth_range", addr_of(adv_timer_reg_pkg::REG_CFG), cfg_word(1'b1, 8'd3));
		cmd("sawtooth_range", CMD_UPDATE);
		cmd("sawtooth_range", CMD_START);
		outside = 0;
		wraps   = 0;
		prev    = 16'd5;
		for (int i = 0; i < 50; i++) begin
			read_count("sawtooth_range", cur);
			if (cur < 16'd5 || cur > 16'd20)
				outside++;
			if (cur < prev)
				wraps++;
			prev = cur;
		end
		check("sawtooth_range reads outside range", 32'd0, 32'(outside));
		check("sawtooth_range wrap seen", 32'd1, 32'(wraps > 0));
		cmd("sawtooth_range", CMD_STOP);
	endtask

	task automatic triangle_shape();
		logic [15:0] prev;
		logic [15:0] cur;
		int          outside;
		int          jumps;
		logic        seen_hi;
		logic        fell;
		apb_write("triangle_shape", addr_of(adv_timer_reg_pkg::REG_CFG), cfg_word(1'b0, 8'd3));
		cmd("triangle_shape", CMD_UPDATE);
		cmd("triangle_shape", CMD_START);
		outside = 0;
		jumps   = 0;
		seen_hi = 1'b0;
		fell    = 1'b0;
		prev    = 16'd5;
		// Reads are 3 cycles apart and ticks 4 cycles apart, so a step is at most 1
		for (int i = 0; i < 60; i++) begin
			read_count("triangle_shape", cur);
			if (cur < 16'd5 || cur > 16'd20)
				outside++;
			if ((cur > prev + 16'd1) || (prev > cur + 16'd1))
				jumps++;
			if (seen_hi && cur < prev)
				fell = 1'b1;
			if (cur == 16'd20)
				seen_hi = 1'b1;
			prev = cur;
		end
		check("triangle_shape reads outside range", 32'd0, 32'(outside));
		check("triangle_shape jumps", 32'd0, 32'(jumps));
		check("triangle_shape falls after hi", 32'd1, 32'(fell));
		cmd("triangle_shape", CMD_STOP);
	endtask

	task automatic wait_ch0_high();
		int waited;
		waited = 0;
		@(posedge HCLK);
		#(CLK_HALF);
		while (!ch_o[0] && waited < 400) begin
			@(posedge HCLK);
			#(CLK_HALF);
			waited++;
		end
		if (!ch_o[0])
			note_timeout("channel 0 never went high");
	endtask

	// Low 10, high 41, period 32 ticks at one tick per cycle
	task automatic channel_ops();
		int   high_cnt;
		int   toggles;
		int   expected;
		logic prev1;
		apb_write("channel_ops", addr_of(adv_timer_reg_pkg::REG_TH), th_word(16'd10, 16'd41));
		apb_write("channel_ops", addr_of(adv_timer_reg_pkg::REG_CFG), cfg_word(1'b1, 8'd0));
		apb_write("channel_ops", addr_of(adv_timer_reg_pkg::REG_CH0),
		          ch_word(adv_timer_pkg::OP_SET_CLR, 16'd20));
		apb_write("channel_ops", addr_of(adv_timer_reg_pkg::REG_CH1),
		          ch_word(adv_timer_pkg::OP_TOGGLE, 16'd30));
		cmd("channel_ops", CMD_UPDATE);
		cmd("channel_ops", CMD_START);
		wait_ch0_high();
		// Channel 0 is high here, the reset command drops it
		cmd("channel_ops", CMD_RST);
		@(posedge HCLK);
		#(CLK_HALF);
		check("channel_ops cleared outputs", 32'd0, 32'(ch_o[1:0]));
		wait_ch0_high();
		high_cnt = 0;
		toggles  = 0;
		prev1    = ch_o[1];
		for (int i = 0; i < 4 * 32; i++) begin
			@(posedge HCLK);
			#(CLK_HALF);
			if (ch_o[0])
				high_cnt++;
			if (ch_o[1] != prev1)
				toggles++;
			prev1 = ch_o[1];
		end
		expected = 4 * (41 - 20);
		check("channel_ops SET_CLR high cycles", 32'(expected),
		      ((high_cnt - expected) <= 4 && (expected - high_cnt) <= 4) ?
		      32'(expected) : 32'(high_cnt));
		check("channel_ops TOGGLE changes", 32'd4, 32'(toggles));
	endtask

	task automatic event_pulses();
		int   rises;
		int   pulses;
		logic prev0;
		apb_write("event_pulses", addr_of(adv_timer_reg_pkg::REG_EVT), 32'h0000_0100);
		rises  = 0;
		pulses = 0;
		#(SAMPLE_DLY);
		prev0  = ch_o[0];
		for (int i = 0; i < 4 * 32; i++) begin
			@(posedge HCLK);
			#(CLK_HALF);
			if (ch_o[0] && !prev0)
				rises++;
			if (events_o[0])
				pulses++;
			prev0 = ch_o[0];
		end
		check("event_pulses channel activity", 32'd1, 32'(rises > 0));
		check("event_pulses enabled", 32'(rises),
		      ((pulses - rises) <= 1 && (rises - pulses) <= 1) ? 32'(rises) : 32'(pulses));
		apb_write("event_pulses", addr_of(adv_timer_reg_pkg::REG_EVT), 32'd0);
		pulses = 0;
		for (int i = 0; i < 4 * 32; i++) begin
			@(posedge HCLK);
			#(CLK_HALF);
			if (events_o != '0)
				pulses++;
		end
		check("event_pulses disabled", 32'd0, 32'(pulses));
		cmd("event_pulses", CMD_STOP);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		HRESETn       = 1'b0;
		PADDR_i       = '0;
		PWDATA_i      = '0;
		PWRITE_i      = 1'b0;
		PSEL_i        = 1'b0;
		PENABLE_i     = 1'b0;
		check_count   = 0;
		error_count   = 0;
		timeout_count = 0;
		rng           = 32'h0db4_6ec0;
		repeat (8) @(posedge HCLK);
		#(DRIVE_DLY);
		HRESETn = 1'b1;
		check("reset ch_o", 32'd0, 32'(ch_o));
		check("reset events_o", 32'd0, 32'(events_o));

		reg_readback();
		reset_and_stop();
		sawtooth_range();
		triangle_shape();
		channel_ops();
		event_pulses();

		$display("Checks: %0d, errors: %0d, timeouts: %0d",
		         check_count, error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* verilog/apb_adv_timer.sv */
// APB PWM timer top level
// Register file, run control, counter, four compare channels, events

`timescale 1ns/100ps
`include "adv_timer_cfg.svh"

module apb_adv_timer (
	input  logic                         HCLK,
	input  logic                         HRESETn,
	input  logic [`ADV_TIMER_ADDR_W-1:0] PADDR_i,
	input  logic [31:0]                  PWDATA_i,
	input  logic                         PWRITE_i,
	input  logic                         PSEL_i,
	input  logic                         PENABLE_i,
	output logic [31:0]                  PRDATA_o,
	output logic                         PREADY_o,
	output logic                         PSLVERR_o,
	output logic [`ADV_TIMER_N_CH-1:0]   ch_o,
	output logic [`ADV_TIMER_N_CH-1:0]   events_o
);

	logic                                            start, stop, update, rst;
	logic                                            run, load, clr;
	logic                                            tick, period_end;
	logic                                            saw;
	logic [`ADV_TIMER_PRESC_W-1:0]                   presc;
	logic [`ADV_TIMER_CNT_W-1:0]                     th_low, th_hi, count;
	logic [`ADV_TIMER_N_CH-1:0][`ADV_TIMER_CNT_W-1:0] ch_th;
	adv_timer_pkg::cmp_op_e [`ADV_TIMER_N_CH-1:0]    ch_op;
	logic [`ADV_TIMER_N_CH-1:0][1:0]                 evt_sel;
	logic [`ADV_TIMER_N_CH-1:0]                      evt_en;

	apb_adv_timer_regs u_regs (
		.HCLK, .HRESETn, .PADDR_i, .PWDATA_i, .PWRITE_i, .PSEL_i, .PENABLE_i,
		.PRDATA_o, .PREADY_o, .PSLVERR_o,
		.count_i   (count),
		.start_o   (start),
		.stop_o    (stop),
		.update_o  (update),
		.rst_o     (rst),
		.saw_o     (saw),
		.presc_o   (presc),
		.th_low_o  (th_low),
		.th_hi_o   (th_hi),
		.ch_th_o   (ch_th),
		.ch_op_o   (ch_op),
		.evt_sel_o (evt_sel),
		.evt_en_o  (evt_en)
	);

	adv_timer_ctrl_fsm u_fsm (
		.HCLK, .HRESETn,
		.start_i      (start),
		.stop_i       (stop),
		.update_i     (update),
		.rst_i        (rst),
		.period_end_i (period_end),
		.run_o        (run),
		.load_o       (load),
		.clr_o        (clr)
	);

	adv_timer_counter u_counter (
		.HCLK, .HRESETn,
		.run_i        (run),
		.load_i       (load),
		.clr_i        (clr),
		.saw_i        (saw),
		.presc_i      (presc),
		.th_low_i     (th_low),
		.th_hi_i      (th_hi),
		.count_o      (count),
		.tick_o       (tick),
		.period_end_o (period_end)
	);

	for (genvar c = 0; c < `ADV_TIMER_N_CH; c++) begin : g_ch
		adv_timer_comp_ch u_ch (
			.HCLK, .HRESETn,
			.load_i       (load),
			.clr_i        (clr),
			.tick_i       (tick),
			.period_end_i (period_end),
			.count_i      (count),
			.th_i         (ch_th[c]),
			.op_i         (ch_op[c]),
			.ch_o         (ch_o[c])
		);
	end

	adv_timer_event_unit u_events (
		.HCLK, .HRESETn,
		.ch_i     (ch_o),
		.sel_i    (evt_sel),
		.en_i     (evt_en),
		.events_o (events_o)
	);

endmodule

/* verilog/adv_timer_event_unit.sv */
// Event outputs
// Per-event channel select, two-flop synchroniser, rising-edge pulse

`timescale 1ns/100ps
`include "adv_timer_cfg.svh"

module adv_timer_event_unit (
	input  logic                               HCLK,
	input  logic                               HRESETn,
	input  logic [`ADV_TIMER_N_CH-1:0]         ch_i,
	input  logic [`ADV_TIMER_N_CH-1:0][1:0]    sel_i,
	input  logic [`ADV_TIMER_N_CH-1:0]         en_i,
	output logic [`ADV_TIMER_N_CH-1:0]         events_o
);

	logic [`ADV_TIMER_N_CH-1:0] sync0_q;
	logic [`ADV_TIMER_N_CH-1:0] sync1_q;
	logic [`ADV_TIMER_N_CH-1:0] last_q;

	// Disabled events keep their flops frozen
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			sync0_q <= '0;
			sync1_q <= '0;
			last_q  <= '0;
		end else begin
			for (int e = 0; e < `ADV_TIMER_N_CH; e++) begin
				if (en_i[e]) begin
					sync0_q[e] <= ch_i[sel_i[e]];
					sync1_q[e] <= sync0_q[e];
					last_q[e]  <= sync1_q[e];
				end
			end
		end
	end

	// Pulse two cycles after the selected bit rises
	assign events_o = en_i & sync1_q & ~last_q;

endmodule

/* verilog/adv_timer_comp_ch.sv */
// Compare channel
// Active threshold and operation, one registered output bit

`timescale 1ns/100ps
`include "adv_timer_cfg.svh"

module adv_timer_comp_ch (
	input  logic                        HCLK,
	input  logic                        HRESETn,
	input  logic                        load_i,
	input  logic                        clr_i,
	input  logic                        tick_i,
	input  logic                        period_end_i,
	input  logic [`ADV_TIMER_CNT_W-1:0] count_i,
	input  logic [`ADV_TIMER_CNT_W-1:0] th_i,
	input  adv_timer_pkg::cmp_op_e      op_i,
	output logic                        ch_o
);

	logic [`ADV_TIMER_CNT_W-1:0] th_q;
	adv_timer_pkg::cmp_op_e      op_q;
	logic                        match;

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			th_q <= '0;
			op_q <= adv_timer_pkg::OP_SET;
		end else if (load_i) begin
			th_q <= th_i;
			op_q <= op_i;
		end
	end

	assign match = tick_i && (count_i == th_q);

	// A match takes priority over the period-end action
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			ch_o <= 1'b0;
		end else if (clr_i) begin
			ch_o <= 1'b0;
		end else begin
			case (op_q)
				adv_timer_pkg::OP_CLR:    if (match) ch_o <= 1'b0;
				adv_timer_pkg::OP_TOGGLE: if (match) ch_o <= !ch_o;
				adv_timer_pkg::OP_SET_CLR: begin
					if (match) ch_o <= 1'b1;
					else if (period_end_i) ch_o <= 1'b0;
				end
				adv_timer_pkg::OP_CLR_SET: begin
					if (match) ch_o <= 1'b0;
					else if (period_end_i) ch_o <= 1'b1;
				end
				default:                  if (match) ch_o <= 1'b1;
			endcase
		end
	end

endmodule

/* verilog/adv_timer_counter.sv */
// Prescaler and main counter
// Sawtooth or up/down triangle between the active thresholds

`timescale 1ns/100ps
`include "adv_timer_cfg.svh"

module adv_timer_counter (
	input  logic                          HCLK,
	input  logic                          HRESETn,
	input  logic                          run_i,
	input  logic                          load_i,
	input  logic                          clr_i,
	input  logic                          saw_i,
	input  logic [`ADV_TIMER_PRESC_W-1:0] presc_i,
	input  logic [`ADV_TIMER_CNT_W-1:0]   th_low_i,
	input  logic [`ADV_TIMER_CNT_W-1:0]   th_hi_i,
	output logic [`ADV_TIMER_CNT_W-1:0]   count_o,
	output logic                          tick_o,
	output logic                          period_end_o
);

	logic                          saw_q;
	logic [`ADV_TIMER_PRESC_W-1:0] presc_q;
	logic [`ADV_TIMER_PRESC_W-1:0] presc_cnt_q;
	logic [`ADV_TIMER_CNT_W-1:0]   low_q;
	logic [`ADV_TIMER_CNT_W-1:0]   hi_q;
	logic                          tick_q;
	logic                          down_q;

	// Active configuration
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			saw_q   <= `ADV_TIMER_SAW_RST;
			presc_q <= `ADV_TIMER_PRESC_RST;
			low_q   <= `ADV_TIMER_TH_LOW_RST;
			hi_q    <= `ADV_TIMER_TH_HI_RST;
		end else if (load_i) begin
			saw_q   <= saw_i;
			presc_q <= presc_i;
			low_q   <= th_low_i;
			hi_q    <= th_hi_i;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Prescaler, first tick presc+1 cycles after run rises

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			presc_cnt_q <= '0;
			tick_q      <= 1'b0;
		end else if (load_i || clr_i || !run_i) begin
			presc_cnt_q <= '0;
			tick_q      <= 1'b0;
		end else begin
			tick_q      <= (presc_cnt_q == presc_q);
			presc_cnt_q <= (presc_cnt_q == presc_q) ? '0 : presc_cnt_q + 1'b1;
		end
	end

	assign tick_o = tick_q && run_i;

	//////////////////////////////////////////////////////////////////////
	// Counter

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			count_o <= `ADV_TIMER_TH_LOW_RST;
			down_q  <= 1'b0;
		end else if (clr_i) begin
			count_o <= low_q;
			down_q  <= 1'b0;
		end else if (load_i) begin
			count_o <= th_low_i;
			down_q  <= 1'b0;
		end else if (tick_o) begin
			if (saw_q) begin
				count_o <= (count_o == hi_q) ? low_q : count_o + 1'b1;
			end else if (!down_q) begin
				if (count_o == hi_q) begin
					count_o <= count_o - 1'b1;
					down_q  <= 1'b1;
				end else begin
					count_o <= count_o + 1'b1;
				end
			end else if (count_o == low_q) begin
				count_o <= count_o + 1'b1;
				down_q  <= 1'b0;
			end else begin
				count_o <= count_o - 1'b1;
			end
		end
	end

	// Wrap in sawtooth, turn at low in triangle
	assign period_end_o = tick_o && (saw_q ? (count_o == hi_q) : (down_q && count_o == low_q));

	a_count_in_range: assert property (@(posedge HCLK) disable iff (!HRESETn)
		run_i && $past(run_i) |-> count_o >= low_q && count_o <= hi_q);

endmodule

/* verilog/adv_timer_ctrl_fsm.sv */
// Run control of the timer
// Start, stop and reset sequencing, deferred configuration load

`timescale 1ns/100ps

module adv_timer_ctrl_fsm (
	input  logic HCLK,
	input  logic HRESETn,
	input  logic start_i,
	input  logic stop_i,
	input  logic update_i,
	input  logic rst_i,
	input  logic period_end_i,
	output logic run_o,
	output logic load_o,
	output logic clr_o
);

	adv_timer_pkg::ctrl_state_e state_q;
	adv_timer_pkg::ctrl_state_e state_d;
	logic                       pending_q;

	// Stop wins over a start in the same cycle
	always_comb begin
		state_d = state_q;
		if (stop_i) begin
			state_d = adv_timer_pkg::ST_IDLE;
		end else begin
			case (state_q)
				adv_timer_pkg::ST_IDLE: if (start_i) state_d = adv_timer_pkg::ST_LOAD;
				adv_timer_pkg::ST_LOAD: state_d = adv_timer_pkg::ST_RUN;
				adv_timer_pkg::ST_RUN:  state_d = adv_timer_pkg::ST_RUN;
				default:                state_d = adv_timer_pkg::ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			state_q   <= adv_timer_pkg::ST_IDLE;
			pending_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// Update while running waits for the end of the period
			if (state_q == adv_timer_pkg::ST_RUN && !stop_i)
				pending_q <= update_i || (pending_q && !period_end_i);
			else
				pending_q <= 1'b0;
		end
	end

	assign run_o  = (state_q == adv_timer_pkg::ST_RUN);
	assign clr_o  = rst_i;
	assign load_o = (state_q == adv_timer_pkg::ST_LOAD) ||
	                (state_q == adv_timer_pkg::ST_IDLE && update_i) ||
	                (state_q == adv_timer_pkg::ST_RUN && pending_q && period_end_i);

	// A load while running follows an update that was still waiting
	a_load_in_run: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(state_q == adv_timer_pkg::ST_RUN && load_o) |->
			period_end_i && $past(update_i || pending_q));

endmodule

/* verilog/apb_adv_timer_regs.sv */
// APB register file of the PWM timer
// Shadow configuration, command strobes and read mux

`timescale 1ns/100ps
`include "adv_timer_cfg.svh"

module apb_adv_timer_regs (
	input  logic                                  HCLK,
	input  logic                                  HRESETn,
	input  logic [`ADV_TIMER_ADDR_W-1:0]          PADDR_i,
	input  logic [31:0]                           PWDATA_i,
	input  logic                                  PWRITE_i,
	input  logic                                  PSEL_i,
	input  logic                                  PENABLE_i,
	output logic [31:0]                           PRDATA_o,
	output logic                                  PREADY_o,
	output logic                                  PSLVERR_o,
	input  logic [`ADV_TIMER_CNT_W-1:0]           count_i,
	output logic                                  start_o,
	output logic                                  stop_o,
	output logic                                  update_o,
	output logic                                  rst_o,
	output logic                                  saw_o,
	output logic [`ADV_TIMER_PRESC_W-1:0]         presc_o,
	output logic [`ADV_TIMER_CNT_W-1:0]           th_low_o,
	output logic [`ADV_TIMER_CNT_W-1:0]           th_hi_o,
	output logic [`ADV_TIMER_N_CH-1:0][`ADV_TIMER_CNT_W-1:0] ch_th_o,
	output adv_timer_pkg::cmp_op_e [`ADV_TIMER_N_CH-1:0]    ch_op_o,
	output logic [`ADV_TIMER_N_CH-1:0][1:0]       evt_sel_o,
	output logic [`ADV_TIMER_N_CH-1:0]            evt_en_o
);

	adv_timer_reg_pkg::reg_addr_e reg_addr;
	logic                         addr_ok;
	logic                         wr_en;
	logic                         wr_cmd;
	logic [1:0]                   ch_idx;

	// Word aligned and inside the map
	assign addr_ok  = (PADDR_i[1:0] == 2'b00) &&
	                  (PADDR_i[`ADV_TIMER_ADDR_W-1:2] < `ADV_TIMER_N_REGS);
	assign reg_addr = adv_timer_reg_pkg::reg_addr_e'(PADDR_i[7:0]);
	assign ch_idx   = 2'(PADDR_i[4:2] - 3'd3);

	assign wr_en     = PSEL_i && PENABLE_i && PWRITE_i && addr_ok;
	assign wr_cmd    = wr_en && (reg_addr == adv_timer_reg_pkg::REG_CMD);
	assign PREADY_o  = 1'b1;
	assign PSLVERR_o = PSEL_i && PENABLE_i && !addr_ok;

	//////////////////////////////////////////////////////////////////////
	// Command strobes, one cycle after the access

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			start_o  <= 1'b0;
			stop_o   <= 1'b0;
			update_o <= 1'b0;
			rst_o    <= 1'b0;
		end else begin
			start_o  <= wr_cmd && PWDATA_i[adv_timer_reg_pkg::CMD_START_BIT];
			stop_o   <= wr_cmd && PWDATA_i[adv_timer_reg_pkg::CMD_STOP_BIT];
			update_o <= wr_cmd && PWDATA_i[adv_timer_reg_pkg::CMD_UPDATE_BIT];
			rst_o    <= wr_cmd && PWDATA_i[adv_timer_reg_pkg::CMD_RST_BIT];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Shadow configuration

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			saw_o     <= `ADV_TIMER_SAW_RST;
			presc_o   <= `ADV_TIMER_PRESC_RST;
			th_low_o  <= `ADV_TIMER_TH_LOW_RST;
			th_hi_o   <= `ADV_TIMER_TH_HI_RST;
			ch_th_o   <= '0;
			evt_sel_o <= '0;
			evt_en_o  <= '0;
			for (int i = 0; i < `ADV_TIMER_N_CH; i++) begin
				ch_op_o[i] <= adv_timer_pkg::OP_SET;
			end
		end else if (wr_en) begin
			case (reg_addr)
				adv_timer_reg_pkg::REG_CFG: begin
					saw_o   <= PWDATA_i[adv_timer_reg_pkg::CFG_SAW_BIT];
					presc_o <= PWDATA_i[adv_timer_reg_pkg::CFG_PRESC_LSB +: `ADV_TIMER_PRESC_W];
				end
				adv_timer_reg_pkg::REG_TH: begin
					th_low_o <= PWDATA_i[`ADV_TIMER_CNT_W-1:0];
					th_hi_o  <= PWDATA_i[adv_timer_reg_pkg::TH_HI_LSB +: `ADV_TIMER_CNT_W];
				end
				adv_timer_reg_pkg::REG_CH0, adv_timer_reg_pkg::REG_CH1,
				adv_timer_reg_pkg::REG_CH2, adv_timer_reg_pkg::REG_CH3: begin
					ch_th_o[ch_idx] <= PWDATA_i[`ADV_TIMER_CNT_W-1:0];
					ch_op_o[ch_idx] <= adv_timer_pkg::cmp_op_e'(
						PWDATA_i[adv_timer_reg_pkg::CH_OP_LSB +: 3]);
				end
				adv_timer_reg_pkg::REG_EVT: begin
					evt_sel_o <= PWDATA_i[adv_timer_reg_pkg::EVT_SEL_LSB +: 2*`ADV_TIMER_N_CH];
					evt_en_o  <= PWDATA_i[adv_timer_reg_pkg::EVT_EN_LSB +: `ADV_TIMER_N_CH];
				end
				default: ;
			endcase
		end
	end

	// Read mux, only fields that exist come back
	always_comb begin
		PRDATA_o = '0;
		if (PSEL_i && PENABLE_i && addr_ok) begin
			case (reg_addr)
				adv_timer_reg_pkg::REG_CFG: begin
					PRDATA_o[adv_timer_reg_pkg::CFG_SAW_BIT] = saw_o;
					PRDATA_o[adv_timer_reg_pkg::CFG_PRESC_LSB +: `ADV_TIMER_PRESC_W] = presc_o;
				end
				adv_timer_reg_pkg::REG_TH: begin
					PRDATA_o[`ADV_TIMER_CNT_W-1:0] = th_low_o;
					PRDATA_o[adv_timer_reg_pkg::TH_HI_LSB +: `ADV_TIMER_CNT_W] = th_hi_o;
				end
				adv_timer_reg_pkg::REG_CH0, adv_timer_reg_pkg::REG_CH1,
				adv_timer_reg_pkg::REG_CH2, adv_timer_reg_pkg::REG_CH3: begin
					PRDATA_o[`ADV_TIMER_CNT_W-1:0] = ch_th_o[ch_idx];
					PRDATA_o[adv_timer_reg_pkg::CH_OP_LSB +: 3] = ch_op_o[ch_idx];
				end
				adv_timer_reg_pkg::REG_EVT: begin
					PRDATA_o[adv_timer_reg_pkg::EVT_SEL_LSB +: 2*`ADV_TIMER_N_CH] = evt_sel_o;
					PRDATA_o[adv_timer_reg_pkg::EVT_EN_LSB +: `ADV_TIMER_N_CH] = evt_en_o;
				end
				adv_timer_reg_pkg::REG_CNT: PRDATA_o[`ADV_TIMER_CNT_W-1:0] = count_i;
				default: ;
			endcase
		end
	end

	// An error response only ends a proper setup/access pair
	a_slverr_in_access: assert property (@(posedge HCLK) disable iff (!HRESETn)
		PSLVERR_o |-> PSEL_i && PENABLE_i && $past(PSEL_i && !PENABLE_i));

endmodule

/* verilog/adv_timer_pkg.sv */
// Timer behaviour types
// Compare channel operations and run-control states

package adv_timer_pkg;

	// Codes 5 to 7 behave as OP_SET
	typedef enum logic [2:0] {
		OP_SET     = 3'd0,
		OP_CLR     = 3'd1,
		OP_TOGGLE  = 3'd2,
		OP_SET_CLR = 3'd3,
		OP_CLR_SET = 3'd4
	} cmp_op_e;

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_LOAD = 2'd1,
		ST_RUN  = 2'd2
	} ctrl_state_e;

endpackage

/* verilog/adv_timer_reg_pkg.sv */
// Register map of the APB PWM timer
// Word offsets and field bit positions

package adv_timer_reg_pkg;

	typedef enum logic [7:0] {
		REG_CMD = 8'h00,
		REG_CFG = 8'h04,
		REG_TH  = 8'h08,
		REG_CH0 = 8'h0C,
		REG_CH1 = 8'h10,
		REG_CH2 = 8'h14,
		REG_CH3 = 8'h18,
		REG_EVT = 8'h1C,
		REG_CNT = 8'h20
	} reg_addr_e;

	// Command strobes, CMD reads back as zero
	localparam int CMD_START_BIT  = 0;
	localparam int CMD_STOP_BIT   = 1;
	localparam int CMD_UPDATE_BIT = 2;
	localparam int CMD_RST_BIT    = 3;

	localparam int CFG_SAW_BIT    = 12;
	localparam int CFG_PRESC_LSB  = 16;
	localparam int TH_HI_LSB      = 16;
	localparam int CH_OP_LSB      = 16;
	localparam int EVT_SEL_LSB    = 0;
	localparam int EVT_EN_LSB     = 8;

endpackage

/* include/adv_timer_cfg.svh */
// Build-time constants of the APB PWM timer
// Bus and counter widths, register count, configuration reset values

`ifndef ADV_TIMER_CFG_SVH
`define ADV_TIMER_CFG_SVH

`define ADV_TIMER_ADDR_W     12
`define ADV_TIMER_CNT_W      16
`define ADV_TIMER_PRESC_W    8
`define ADV_TIMER_N_CH       4
`define ADV_TIMER_N_REGS     9

`define ADV_TIMER_SAW_RST    1'b1
`define ADV_TIMER_PRESC_RST  8'h00
`define ADV_TIMER_TH_LOW_RST 16'h0000
`define ADV_TIMER_TH_HI_RST  16'hFFFF

`endif
